// File: src/store_mem_config.svh
`ifndef STORE_MEM_CONFIG_SVH
`define STORE_MEM_CONFIG_SVH

// Number of store ports feeding the write arbiter
`define STORE_PORTS 2

// Number of control ports announcing store counts
`define CTRL_PORTS 2

// Memory word width in bits
`define DATA_W 32

// Word address width, 256 words deep
`define ADDR_W 8

// Width of a store count announcement and of the pending counter
`define COUNT_W 32

`endif

// File: src/storeMemPkg.sv
`include "store_mem_config.svh"

package storeMemPkg;

  // One memory word
  typedef logic [`DATA_W-1:0] dataT;

  // Word address into the block RAM
  typedef logic [`ADDR_W-1:0] addrT;

  // Number of stores, announced or outstanding
  typedef logic [`COUNT_W-1:0] countT;

  // A complete store as seen on a store port and on the write bus.
  // Address sits in the upper bits, data in the lower bits.
  typedef struct packed {
    addrT addr;
    dataT data;
  } storeReqT;

endpackage

// File: src/writeArbiter.sv
`include "store_mem_config.svh"

module writeArbiter #(
  parameter int NUM_STORE = `STORE_PORTS
) (
  // Store ports
  input  storeMemPkg::storeReqT [NUM_STORE-1:0] storeReq,
  input  logic                  [NUM_STORE-1:0] addrValid,
  input  logic                  [NUM_STORE-1:0] dataValid,
  output logic                  [NUM_STORE-1:0] storeReady,

  // Write bus towards the RAM
  output logic                                  writeEn,
  output storeMemPkg::storeReqT                 writeReq
);

  import storeMemPkg::*;

  // A port only competes once both address and data are present
  logic [NUM_STORE-1:0] eligible;

  // One-hot grant, or all zero when nobody is eligible
  logic [NUM_STORE-1:0] grant;

  // Bit i is set when some port below i is eligible
  logic [NUM_STORE:0]   blocked;

  // Request of the granted port
  storeReqT             selReq;

  assign eligible   = addrValid & dataValid;
  assign blocked[0] = 1'b0;

  // Priority chain, lowest index wins
  for (genvar i = 0; i < NUM_STORE; i++) begin : gPriority
    assign grant[i]       = eligible[i] & ~blocked[i];
    assign blocked[i + 1] = blocked[i] | eligible[i];
  end

  // Grant is one-hot so the order of this loop does not matter
  always_comb begin
    selReq = '0;
    for (int i = 0; i < NUM_STORE; i++) begin
      if (grant[i]) begin
        selReq = storeReq[i];
      end
    end
  end

  // Ready goes back in the same cycle as the valids
  assign storeReady = grant;

  // Transfer happens whenever any port holds the grant
  assign writeEn  = |grant;
  assign writeReq = selReq;

endmodule

// File: src/storeMemController.sv
`include "store_mem_config.svh"

module storeMemController #(
  parameter int NUM_STORE = `STORE_PORTS,
  parameter int NUM_CTRL  = `CTRL_PORTS
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Control ports, always accepted
  input  storeMemPkg::countT    [NUM_CTRL-1:0]  ctrlCount,
  input  logic                  [NUM_CTRL-1:0]  ctrlValid,

  // Store ports
  input  storeMemPkg::storeReqT [NUM_STORE-1:0] storeReq,
  input  logic                  [NUM_STORE-1:0] addrValid,
  input  logic                  [NUM_STORE-1:0] dataValid,
  output logic                  [NUM_STORE-1:0] storeReady,

  // Write bus towards the RAM
  output logic                                  writeEn,
  output storeMemPkg::storeReqT                 writeReq,

  // High while no store is outstanding or being announced
  output logic                                  memDone
);

  import storeMemPkg::*;

  // Stores announced but not yet written
  countT pendingCount;

  // Sum of all announcements arriving this cycle
  countT announced;

  writeArbiter #(
    .NUM_STORE (NUM_STORE)
  ) uWriteArbiter (
    .storeReq   (storeReq),
    .addrValid  (addrValid),
    .dataValid  (dataValid),
    .storeReady (storeReady),
    .writeEn    (writeEn),
    .writeReq   (writeReq)
  );

  // Several control ports may announce in the same cycle
  always_comb begin
    announced = '0;
    for (int j = 0; j < NUM_CTRL; j++) begin
      if (ctrlValid[j]) begin
        announced = announced + ctrlCount[j];
      end
    end
  end

  // Announcements and the completed write both land in one update.
  // Wraps modulo 2**COUNT_W like the announcements themselves.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pendingCount <= '0;
    end else begin
      pendingCount <= pendingCount + announced - countT'(writeEn);
    end
  end

  // A pending announcement also keeps done low
  assign memDone = (pendingCount == '0) && (ctrlValid == '0);

endmodule

// File: src/blockRam.sv
`include "store_mem_config.svh"

module blockRam #(
  parameter int DEPTH_LOG2 = `ADDR_W
) (
  input  logic                  clk,
  input  logic                  rst,

  // Write port, fed by the arbiter
  input  logic                  writeEn,
  input  storeMemPkg::storeReqT writeReq,

  // Read-back port
  input  logic                  rdEn,
  input  storeMemPkg::addrT     rdAddr,
  output storeMemPkg::dataT     rdData
);

  import storeMemPkg::*;

  dataT mem [2**DEPTH_LOG2];

  logic [DEPTH_LOG2-1:0] wrIdx;
  logic [DEPTH_LOG2-1:0] rdIdx;

  assign wrIdx = writeReq.addr[DEPTH_LOG2-1:0];
  assign rdIdx = rdAddr[DEPTH_LOG2-1:0];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[wrIdx] <= writeReq.data;
    end
  end

  // Registered read, a same-edge write to the same word wins
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdData <= '0;
    end else if (rdEn) begin
      if (writeEn && (wrIdx == rdIdx)) begin
        rdData <= writeReq.data;
      end else begin
        rdData <= mem[rdIdx];
      end
    end
  end

endmodule

// File: src/storeSubsystem.sv
`include "store_mem_config.svh"

module storeSubsystem (
  input  logic                                      clk,
  input  logic                                      rst,

  // Control ports
  input  storeMemPkg::countT    [`CTRL_PORTS-1:0]   ctrlCount,
  input  logic                  [`CTRL_PORTS-1:0]   ctrlValid,

  // Store ports
  input  storeMemPkg::storeReqT [`STORE_PORTS-1:0]  storeReq,
  input  logic                  [`STORE_PORTS-1:0]  addrValid,
  input  logic                  [`STORE_PORTS-1:0]  dataValid,
  output logic                  [`STORE_PORTS-1:0]  storeReady,

  // Completion level
  output logic                                      memDone,

  // Read-back access to the RAM
  input  logic                                      rdEn,
  input  storeMemPkg::addrT                         rdAddr,
  output storeMemPkg::dataT                         rdData
);

  import storeMemPkg::*;

  // Write bus between controller and RAM
  logic     writeEn;
  storeReqT writeReq;

  storeMemController #(
    .NUM_STORE (`STORE_PORTS),
    .NUM_CTRL  (`CTRL_PORTS)
  ) uController (
    .clk        (clk),
    .rst        (rst),
    .ctrlCount  (ctrlCount),
    .ctrlValid  (ctrlValid),
    .storeReq   (storeReq),
    .addrValid  (addrValid),
    .dataValid  (dataValid),
    .storeReady (storeReady),
    .writeEn    (writeEn),
    .writeReq   (writeReq),
    .memDone    (memDone)
  );

  // Full address range of the write bus is backed by RAM
  blockRam #(
    .DEPTH_LOG2 (`ADDR_W)
  ) uBlockRam (
    .clk      (clk),
    .rst      (rst),
    .writeEn  (writeEn),
    .writeReq (writeReq),
    .rdEn     (rdEn),
    .rdAddr   (rdAddr),
    .rdData   (rdData)
  );

endmodule

// File: verification/storeSubsystem_chk.sv
`include "store_mem_config.svh"

module storeSubsystem_chk #(
  parameter int NUM_STORE = `STORE_PORTS,
  parameter int NUM_CTRL  = `CTRL_PORTS
) (
  input logic                 clk,
  input logic                 rst,
  input logic [NUM_STORE-1:0] addrValid,
  input logic [NUM_STORE-1:0] dataValid,
  input logic [NUM_STORE-1:0] storeReady,
  input logic                 writeEn,
  input logic [NUM_CTRL-1:0]  ctrlValid,
  input logic                 memDone
);

  // At most one store port wins per cycle
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(storeReady))
    else $error("More than one store port granted in the same cycle");

  // A grant needs both halves of the join
  grantNeedsJoin: assert property (@(posedge clk) disable iff (rst)
    (storeReady & ~(addrValid & dataValid)) == '0)
    else $error("Store port granted without both address and data valid");

  writeNeedsGrant: assert property (@(posedge clk) disable iff (rst)
    writeEn |-> (storeReady != '0))
    else $error("Write enable without any granted store port");

  doneMeansIdle: assert property (@(posedge clk) disable iff (rst)
    memDone |-> (ctrlValid == '0))
    else $error("Done high while a control port announces stores");

endmodule

bind storeMemController storeSubsystem_chk #(
  .NUM_STORE (NUM_STORE),
  .NUM_CTRL  (NUM_CTRL)
) chk (
  .clk          (clk),
  .rst          (rst),
  .addrValid    (addrValid),
  .dataValid    (dataValid),
  .storeReady   (storeReady),
  .writeEn      (writeEn),
  .ctrlValid    (ctrlValid),
  .memDone      (memDone)
);

// File: verification/storeSubsystemTb.sv
`include "store_mem_config.svh"

module storeSubsystemTb;

  import storeMemPkg::*;

  localparam int CLK_HALF     = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 10;
  localparam int STIM_CYCLES  = 400;
  localparam int MEM_WORDS    = 2 ** `ADDR_W;
  // Reset, random phase, one read per word, and slack for draining held stores
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + STIM_CYCLES + MEM_WORDS + 100;

  logic                         clk;
  logic                         rst;
  countT    [`CTRL_PORTS-1:0]   ctrlCount;
  logic     [`CTRL_PORTS-1:0]   ctrlValid;
  storeReqT [`STORE_PORTS-1:0]  storeReq;
  logic     [`STORE_PORTS-1:0]  addrValid;
  logic     [`STORE_PORTS-1:0]  dataValid;
  logic     [`STORE_PORTS-1:0]  storeReady;
  logic                         memDone;
  logic                         rdEn;
  addrT                         rdAddr;
  dataT                         rdData;

  int seed;
  int cycleCount;

  // Reference model
  dataT                     modelMem [MEM_WORDS];
  logic [MEM_WORDS-1:0]     written;
  countT                    modelPending;
  dataT                     expRdData;
  logic [`STORE_PORTS-1:0]  active;
  logic [`STORE_PORTS-1:0]  accepted;

  storeSubsystem dut (
    .clk        (clk),
    .rst        (rst),
    .ctrlCount  (ctrlCount),
    .ctrlValid  (ctrlValid),
    .storeReq   (storeReq),
    .addrValid  (addrValid),
    .dataValid  (dataValid),
    .storeReady (storeReady),
    .memDone    (memDone),
    .rdEn       (rdEn),
    .rdAddr     (rdAddr),
    .rdData     (rdData)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > TIMEOUT_CYCLES) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    end
  end

  function automatic logic [31:0] nextRandom();
    return $random(seed);
  endfunction

  task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("Error at time %0t: %s mismatch, expected %h, got %h",
               $time, what, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // New stimulus for one cycle, applied shortly after the rising edge
  task automatic driveInputs(input bit newReqs, input bit announce,
                             input bit readEn, input addrT readAddr);
    logic [31:0] r;
    for (int i = 0; i < `STORE_PORTS; i++) begin
      if (accepted[i]) begin
        active[i]    = 1'b0;
        addrValid[i] = 1'b0;
        dataValid[i] = 1'b0;
      end
      r = nextRandom();
      if (!active[i] && newReqs && (r[31:30] != 2'b00)) begin
        active[i] = 1'b1;
        // Narrow address range so words get overwritten
        storeReq[i].addr = addrT'(r[5:0]);
        storeReq[i].data = dataT'(nextRandom());
      end else if (!active[i]) begin
        // Idle port carries junk that must be ignored
        storeReq[i].addr = addrT'(r[15:8]);
        storeReq[i].data = dataT'(nextRandom());
      end
      r = nextRandom();
      if (active[i]) begin
        // Valids come up independently and stay up until accepted
        addrValid[i] = addrValid[i] | r[0];
        dataValid[i] = dataValid[i] | r[1];
      end else begin
        addrValid[i] = 1'b0;
        dataValid[i] = 1'b0;
      end
    end
    for (int j = 0; j < `CTRL_PORTS; j++) begin
      r = nextRandom();
      ctrlValid[j] = announce && (r[1:0] == 2'b00);
      ctrlCount[j] = ctrlValid[j] ? countT'(r[3:2]) : countT'(r);
    end
    accepted = '0;
    rdEn     = readEn;
    rdAddr   = readAddr;
  endtask

  // Check outputs while they are stable, then advance the model past the next edge
  task automatic stepCycle();
    logic [`STORE_PORTS-1:0] eligible;
    logic [`STORE_PORTS-1:0] expGrant;
    logic                    expDone;
    countT                   announced;
    @(negedge clk);
    eligible = addrValid & dataValid;
    expGrant = '0;
    for (int i = 0; i < `STORE_PORTS; i++) begin
      if (eligible[i] && (expGrant == '0)) begin
        expGrant[i] = 1'b1;
      end
    end
    expDone = (modelPending == '0) && (ctrlValid == '0);
    checkEqual(64'(storeReady), 64'(expGrant), "storeReady");
    checkEqual(64'(dut.writeEn), 64'(expGrant != '0), "writeEn");
    checkEqual(64'(memDone), 64'(expDone), "memDone");
    checkEqual(64'(rdData), 64'(expRdData), "rdData");
    announced = '0;
    for (int j = 0; j < `CTRL_PORTS; j++) begin
      if (ctrlValid[j]) begin
        announced = announced + ctrlCount[j];
      end
    end
    modelPending = modelPending + announced;
    for (int i = 0; i < `STORE_PORTS; i++) begin
      if (expGrant[i]) begin
        checkEqual(64'(dut.writeReq), 64'(storeReq[i]), "writeReq");
        modelMem[storeReq[i].addr] = storeReq[i].data;
        written[storeReq[i].addr]  = 1'b1;
        modelPending = modelPending - countT'(1);
      end
    end
    // Write-first, a read at the same edge sees the new word
    if (rdEn) begin
      expRdData = modelMem[rdAddr];
    end
    accepted = expGrant;
  endtask

  task automatic runCycle(input bit newReqs, input bit announce,
                          input bit readEn, input addrT readAddr);
    @(posedge clk);
    #DRIVE_DLY;
    driveInputs(newReqs, announce, readEn, readAddr);
    stepCycle();
  endtask

  initial begin
    seed         = 32'h39dc_5fab;
    cycleCount   = 0;
    clk          = 1'b0;
    rst          = 1'b1;
    ctrlCount    = '0;
    ctrlValid    = '0;
    storeReq     = '0;
    addrValid    = '0;
    dataValid    = '0;
    rdEn         = 1'b0;
    rdAddr       = '0;
    modelPending = '0;
    expRdData    = '0;
    written      = '0;
    active       = '0;
    accepted     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // Quiet inputs right after reset
    repeat (2) runCycle(1'b0, 1'b0, 1'b0, '0);

    repeat (STIM_CYCLES) runCycle(1'b1, 1'b1, 1'b0, '0);

    // Finish the stores still held by the sources
    while ((active & ~accepted) != '0) begin
      runCycle(1'b0, 1'b0, 1'b0, '0);
    end

    // Read back every written word
    for (int a = 0; a < MEM_WORDS; a++) begin
      if (written[a]) begin
        runCycle(1'b0, 1'b0, 1'b1, addrT'(a));
      end
    end
    runCycle(1'b0, 1'b0, 1'b0, '0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/storeMemPkg.sv
src/writeArbiter.sv
src/storeMemController.sv
src/blockRam.sv
src/storeSubsystem.sv
verification/storeSubsystem_chk.sv
verification/storeSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= storeSubsystemTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
